//--- hdl/dnn_pkg.sv
package dnn_pkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int OP_WIDTH      = 16;  // one lane operand
  localparam int ACC_GUARD     = 4;   // headroom bits above the full product
  localparam int WB_ADDR_W     = 4;   // 16 weights per PU
  localparam int LAYER_PARAM_W = 5;   // group length / group count fields

  // ============================================================
  // vector types
  // ============================================================

  // signed lane operand
  typedef logic signed [OP_WIDTH-1:0] op_t;

  // lane accumulator, full product plus guard bits
  typedef logic signed [2*OP_WIDTH+ACC_GUARD-1:0] acc_t;

  // weight buffer address, also the position inside a group
  typedef logic [WB_ADDR_W-1:0] wb_addr_t;

  // group length (1..16) or group count
  typedef logic [LAYER_PARAM_W-1:0] layer_param_t;

  // ============================================================
  // controller FSM
  // ============================================================
  typedef enum logic [1:0] {
    IDLE   = 2'd0,  // waiting for start
    RUN    = 2'd1,  // popping input vectors
    DRAIN  = 2'd2,  // last vectors still in the pipe
    FINISH = 2'd3   // wait for results to leave, then done
  } ctrl_state_t;

endpackage

//--- hdl/stream_fifo.sv
module stream_fifo #(
  parameter int DEPTH_LOG2 = 4,
  parameter int WIDTH      = 64
)(
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             empty,
  output logic             full
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;  // one extra bit to tell full from empty
  logic                  do_push;
  logic                  do_pop;

  assign do_push = push && !full;   // a push into a full FIFO is dropped
  assign do_pop  = pop && !empty;

  // head of the queue is visible without a read cycle
  assign pop_data = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == DEPTH[DEPTH_LOG2:0]);

  // storage
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // pointers and occupancy
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

//--- hdl/vectorgen.sv
module vectorgen
  import dnn_pkg::*;
#(
  parameter int NUM_PE   = 4,
  parameter int OP_WIDTH = dnn_pkg::OP_WIDTH
)(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       fifo_pop,
  input  logic [NUM_PE*OP_WIDTH-1:0] fifo_data,
  input  logic                       pop_first,
  input  logic                       pop_last,
  input  logic [NUM_PE-1:0]          vecgen_mask,
  output logic                       vec_valid,
  output logic [NUM_PE*OP_WIDTH-1:0] vec_data,
  output logic                       vec_first,
  output logic                       vec_last,
  output wb_addr_t                   vec_index
);

  logic [NUM_PE*OP_WIDTH-1:0] masked_data;

  // zero every lane whose mask bit is clear
  always_comb
  begin
    for (int l = 0; l < NUM_PE; l++)
      masked_data[l*OP_WIDTH +: OP_WIDTH] =
        vecgen_mask[l] ? fifo_data[l*OP_WIDTH +: OP_WIDTH] : '0;
  end

  // payload, only meaningful with vec_valid
  always_ff @(posedge clk)
  begin
    if (fifo_pop)
      vec_data <= masked_data;
  end

  // valid, group tags and position travel with the data
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      vec_valid <= 1'b0;
      vec_first <= 1'b0;
      vec_last  <= 1'b0;
      vec_index <= '0;
    end
    else
    begin
      vec_valid <= fifo_pop;
      if (fifo_pop)
      begin
        vec_first <= pop_first;
        vec_last  <= pop_last;
        if (pop_first)
          vec_index <= '0;  // new group starts at weight 0
        else
          vec_index <= vec_index + 1'b1;
      end
    end
  end

endmodule

//--- hdl/pu_controller.sv
module pu_controller
  import dnn_pkg::*;
#(
  parameter int  NUM_PU = 2,
  parameter int  NUM_PE = 4,
  localparam int LANE_W = $clog2(NUM_PE + 1)
)(
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  layer_param_t      cfg_group_len,
  input  layer_param_t      cfg_num_groups,
  input  logic [LANE_W-1:0] cfg_active_lanes,
  input  logic              cfg_relu,
  input  logic              fifo_empty,
  input  logic [NUM_PU-1:0] result_pending,
  output logic              fifo_pop,
  output logic              pop_first,
  output logic              pop_last,
  output logic [NUM_PE-1:0] vecgen_mask,
  output logic              relu,
  output logic              done,
  output logic              busy
);

  ctrl_state_t  state;
  layer_param_t group_len;       // latched configuration
  layer_param_t num_groups;
  layer_param_t pos;             // position inside the current group
  layer_param_t group_cnt;       // groups fully popped
  logic         last_in_flight;  // group end popped last cycle, pending not yet visible
  logic         drain_wait;
  logic         group_stall;
  logic         at_group_end;
  logic         at_final_group;

  // ============================================================
  // pop control
  // ============================================================

  // a new group may only start once the previous result has left every PU
  assign group_stall = (pos == '0) && (last_in_flight || (|result_pending));

  assign fifo_pop       = (state == RUN) && !fifo_empty && !group_stall;
  assign at_group_end   = (pos == group_len - 1'b1);
  assign at_final_group = (group_cnt == num_groups - 1'b1);
  assign pop_first      = fifo_pop && (pos == '0);
  assign pop_last       = fifo_pop && at_group_end;

  assign done = (state == FINISH) && !(|result_pending);  // first cycle with nothing left
  assign busy = (state != IDLE);

  // ============================================================
  // FSM
  // ============================================================
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state          <= IDLE;
      group_len      <= '0;
      num_groups     <= '0;
      pos            <= '0;
      group_cnt      <= '0;
      relu           <= 1'b0;
      vecgen_mask    <= '0;
      last_in_flight <= 1'b0;
      drain_wait     <= 1'b0;
    end
    else
    begin
      last_in_flight <= pop_last;
      case (state)
        IDLE:
        begin
          if (start)
          begin
            group_len  <= cfg_group_len;
            num_groups <= cfg_num_groups;
            relu       <= cfg_relu;
            pos        <= '0;
            group_cnt  <= '0;
            drain_wait <= 1'b0;
            for (int l = 0; l < NUM_PE; l++)
              vecgen_mask[l] <= (l < cfg_active_lanes);  // lower lanes active
            state <= (cfg_num_groups == '0) ? FINISH : RUN;
          end
        end

        RUN:
        begin
          if (fifo_pop)
          begin
            if (at_group_end)
            begin
              pos       <= '0;
              group_cnt <= group_cnt + 1'b1;
              if (at_final_group)
                state <= DRAIN;
            end
            else
              pos <= pos + 1'b1;
          end
        end

        DRAIN:
        begin
          // vecgen stage plus accumulate stage
          drain_wait <= 1'b1;
          if (drain_wait)
            state <= FINISH;
        end

        FINISH:
        begin
          if (!(|result_pending))
            state <= IDLE;
        end

        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- hdl/processing_unit.sv
module processing_unit
  import dnn_pkg::*;
#(
  parameter int PU_ID    = 0,
  parameter int PU_SEL_W = 1,
  parameter int NUM_PE   = 4,
  parameter int OP_WIDTH = dnn_pkg::OP_WIDTH
)(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       busy,
  input  logic                       wb_write,
  input  logic [PU_SEL_W-1:0]        wb_pu,
  input  wb_addr_t                   wb_addr,
  input  op_t                        wb_data,
  input  logic                       relu,
  input  logic                       vec_valid,
  input  logic [NUM_PE*OP_WIDTH-1:0] vec_data,
  input  logic                       vec_first,
  input  logic                       vec_last,
  input  wb_addr_t                   vec_index,
  input  logic                       outbuf_full,
  output logic                       result_pending,
  output logic                       out_push,
  output logic [NUM_PE*OP_WIDTH-1:0] out_data
);

  localparam int WB_DEPTH = 1 << WB_ADDR_W;

  op_t  wb_mem [WB_DEPTH];
  op_t  weight;
  logic wb_sel;
  logic store_result;

  // ============================================================
  // weight buffer
  // ============================================================
  assign wb_sel = wb_write && !busy && (wb_pu == PU_SEL_W'(PU_ID));

  always_ff @(posedge clk)
  begin
    if (wb_sel)
      wb_mem[wb_addr] <= wb_data;
  end

  assign weight = wb_mem[vec_index];  // one weight shared by all lanes

  // ============================================================
  // lanes
  // ============================================================
  assign store_result = vec_valid && vec_last;

  for (genvar l = 0; l < NUM_PE; l++)
  begin : g_lane
    op_t  lane_in;
    acc_t acc;
    acc_t lane_sum;

    assign lane_in  = vec_data[l*OP_WIDTH +: OP_WIDTH];
    // fresh sum on the first vector of a group
    assign lane_sum = (vec_first ? acc_t'(0) : acc) + acc_t'(lane_in) * acc_t'(weight);

    always_ff @(posedge clk)
    begin
      if (vec_valid)
        acc <= lane_sum;
    end

    // held until the push, rectified when relu is set
    always_ff @(posedge clk)
    begin
      if (store_result)
      begin
        if (relu && lane_sum[$bits(acc_t)-1])
          out_data[l*OP_WIDTH +: OP_WIDTH] <= '0;
        else
          out_data[l*OP_WIDTH +: OP_WIDTH] <= lane_sum[OP_WIDTH-1:0];  // truncate
      end
    end
  end

  // ============================================================
  // output handshake
  // ============================================================
  assign out_push = result_pending && !outbuf_full;

  always_ff @(posedge clk)
  begin
    if (reset)
      result_pending <= 1'b0;
    else if (store_result)
      result_pending <= 1'b1;
    else if (out_push)
      result_pending <= 1'b0;
  end

endmodule

//--- hdl/dnn_accelerator.sv
module dnn_accelerator
  import dnn_pkg::*;
#(
  parameter int  NUM_PU          = 2,
  parameter int  NUM_PE          = 4,
  parameter int  OP_WIDTH        = dnn_pkg::OP_WIDTH,
  parameter int  FIFO_DEPTH_LOG2 = 4,
  localparam int PU_SEL_W        = (NUM_PU > 1) ? $clog2(NUM_PU) : 1,
  localparam int LANE_W          = $clog2(NUM_PE + 1),
  localparam int PU_DATA_W       = NUM_PE * OP_WIDTH
)(
  input  logic                          clk,
  input  logic                          reset,
  // layer configuration, sampled on start
  input  logic                          start,
  input  layer_param_t                  cfg_group_len,
  input  layer_param_t                  cfg_num_groups,
  input  logic [LANE_W-1:0]             cfg_active_lanes,
  input  logic                          cfg_relu,
  output logic                          done,
  // input vectors
  input  logic                          stream_push,
  input  logic [PU_DATA_W-1:0]          stream_data,
  output logic                          stream_full,
  // weight loading, idle only
  input  logic                          wb_write,
  input  logic [PU_SEL_W-1:0]           wb_pu,
  input  wb_addr_t                      wb_addr,
  input  op_t                           wb_data,
  // results
  output logic [NUM_PU-1:0]             out_push,
  output logic [NUM_PU*PU_DATA_W-1:0]   out_data,
  input  logic [NUM_PU-1:0]             outbuf_full
);

  logic                 fifo_empty;
  logic                 fifo_pop;
  logic [PU_DATA_W-1:0] fifo_data;
  logic                 pop_first;
  logic                 pop_last;
  logic [NUM_PE-1:0]    vecgen_mask;
  logic                 relu;
  logic                 busy;
  logic [NUM_PU-1:0]    result_pending;
  logic                 vec_valid;
  logic [PU_DATA_W-1:0] vec_data;
  logic                 vec_first;
  logic                 vec_last;
  wb_addr_t             vec_index;

  // ============================================================
  // input stream
  // ============================================================
  stream_fifo #(
    .DEPTH_LOG2 (FIFO_DEPTH_LOG2),
    .WIDTH      (PU_DATA_W)
  ) u_stream_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (stream_push),
    .push_data (stream_data),
    .pop       (fifo_pop),
    .pop_data  (fifo_data),
    .empty     (fifo_empty),
    .full      (stream_full)
  );

  vectorgen #(
    .NUM_PE   (NUM_PE),
    .OP_WIDTH (OP_WIDTH)
  ) u_vectorgen (
    .clk         (clk),
    .reset       (reset),
    .fifo_pop    (fifo_pop),
    .fifo_data   (fifo_data),
    .pop_first   (pop_first),
    .pop_last    (pop_last),
    .vecgen_mask (vecgen_mask),
    .vec_valid   (vec_valid),
    .vec_data    (vec_data),
    .vec_first   (vec_first),
    .vec_last    (vec_last),
    .vec_index   (vec_index)
  );

  // ============================================================
  // control
  // ============================================================
  pu_controller #(
    .NUM_PU (NUM_PU),
    .NUM_PE (NUM_PE)
  ) u_controller (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .cfg_group_len    (cfg_group_len),
    .cfg_num_groups   (cfg_num_groups),
    .cfg_active_lanes (cfg_active_lanes),
    .cfg_relu         (cfg_relu),
    .fifo_empty       (fifo_empty),
    .result_pending   (result_pending),
    .fifo_pop         (fifo_pop),
    .pop_first        (pop_first),
    .pop_last         (pop_last),
    .vecgen_mask      (vecgen_mask),
    .relu             (relu),
    .done             (done),
    .busy             (busy)
  );

  // ============================================================
  // PU array, all fed by the same vector
  // ============================================================
  for (genvar i = 0; i < NUM_PU; i++)
  begin : g_pu
    processing_unit #(
      .PU_ID    (i),
      .PU_SEL_W (PU_SEL_W),
      .NUM_PE   (NUM_PE),
      .OP_WIDTH (OP_WIDTH)
    ) u_pu (
      .clk            (clk),
      .reset          (reset),
      .busy           (busy),
      .wb_write       (wb_write),
      .wb_pu          (wb_pu),
      .wb_addr        (wb_addr),
      .wb_data        (wb_data),
      .relu           (relu),
      .vec_valid      (vec_valid),
      .vec_data       (vec_data),
      .vec_first      (vec_first),
      .vec_last       (vec_last),
      .vec_index      (vec_index),
      .outbuf_full    (outbuf_full[i]),
      .result_pending (result_pending[i]),
      .out_push       (out_push[i]),
      .out_data       (out_data[i*PU_DATA_W +: PU_DATA_W])
    );
  end

endmodule

//--- verif/clock_gen.sv
module clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 10
)(
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset held for the first cycles, released on a rising edge
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- verif/tb_dnn_accelerator.sv
module tb_dnn_accelerator
  import dnn_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PU      = 2;
  localparam int NUM_PE      = 4;
  localparam int VEC_W       = NUM_PE * OP_WIDTH;
  localparam int LANE_W      = $clog2(NUM_PE + 1);
  localparam int CLK_PERIOD  = 40;
  localparam int HOLD_CYCLES = 80;   // outbuf_full held this long after start
  localparam int MAX_VECS    = 512;
  localparam int MAX_GROUPS  = 32;
  localparam int NUM_TESTS   = 6;
  localparam int FIFO_DEPTH  = 16;   // stream FIFO entries

  // ============================================================
  // test table, one column per test
  // ============================================================
  localparam int T_LEN    [NUM_TESTS] = '{4, 3, 5, 4, 16, 1};
  localparam int T_GROUPS [NUM_TESTS] = '{3, 2, 3, 4, 3, 5};
  localparam int T_LANES  [NUM_TESTS] = '{4, 2, 4, 3, 4, 1};
  localparam int T_RELU   [NUM_TESTS] = '{0, 0, 1, 0, 0, 1};
  localparam int T_HOLD   [NUM_TESTS] = '{0, 0, 0, 1, 2, 0};  // outbuf_full bits to hold
  localparam int T_SEED   [NUM_TESTS] = '{0, 1, 2, 3, 4, 5};

  logic                    clk;
  logic                    reset;
  logic                    start;
  layer_param_t            cfg_group_len;
  layer_param_t            cfg_num_groups;
  logic [LANE_W-1:0]       cfg_active_lanes;
  logic                    cfg_relu;
  logic                    done;
  logic                    stream_push;
  logic [VEC_W-1:0]        stream_data;
  logic                    stream_full;
  logic                    wb_write;
  logic                    wb_pu;
  wb_addr_t                wb_addr;
  op_t                     wb_data;
  logic [NUM_PU-1:0]       out_push;
  logic [NUM_PU*VEC_W-1:0] out_data;
  logic [NUM_PU-1:0]       outbuf_full;

  op_t              weight_mem [NUM_PU][16];
  logic [VEC_W-1:0] vec_mem [MAX_VECS];
  logic [VEC_W-1:0] exp_mem [NUM_PU][MAX_GROUPS];
  int               seed;
  int               exp_groups = 0;
  int               base_cnt [NUM_PU] = '{default: 0};
  int               done_base = 0;
  int               run_errors = 0;
  // monitor counters
  int               got_cnt [NUM_PU] = '{default: 0};
  int               done_cnt = 0;
  int               checks = 0;
  int               value_errors = 0;
  int               flow_errors = 0;
  logic             push_prev = 1'b0;  // any PU pushed in the previous cycle

  clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (10)
  ) u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  dnn_accelerator #(
    .NUM_PU (NUM_PU),
    .NUM_PE (NUM_PE)
  ) DUT (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .cfg_group_len    (cfg_group_len),
    .cfg_num_groups   (cfg_num_groups),
    .cfg_active_lanes (cfg_active_lanes),
    .cfg_relu         (cfg_relu),
    .done             (done),
    .stream_push      (stream_push),
    .stream_data      (stream_data),
    .stream_full      (stream_full),
    .wb_write         (wb_write),
    .wb_pu            (wb_pu),
    .wb_addr          (wb_addr),
    .wb_data          (wb_data),
    .out_push         (out_push),
    .out_data         (out_data),
    .outbuf_full      (outbuf_full)
  );

  // ============================================================
  // reference model
  // ============================================================
  function automatic logic [VEC_W-1:0] expected_result(input int p, input int g, input int row);
    logic [VEC_W-1:0] res;
    longint           acc;
    int               len;
    len = T_LEN[row];
    res = '0;
    for (int l = 0; l < NUM_PE; l++)
    begin
      acc = 0;
      if (l < T_LANES[row])  // masked lanes stay zero
        for (int k = 0; k < len; k++)
          acc += longint'($signed(vec_mem[g*len+k][l*OP_WIDTH +: OP_WIDTH]))
                 * longint'(weight_mem[p][k]);
      if (T_RELU[row] != 0 && acc < 0)
        acc = 0;
      res[l*OP_WIDTH +: OP_WIDTH] = acc[OP_WIDTH-1:0];  // keep low bits
    end
    return res;
  endfunction

  task automatic prepare_data(input int row);
    int rnd;
    int n;
    seed = 32'hdacf + T_SEED[row];
    for (int p = 0; p < NUM_PU; p++)
      for (int k = 0; k < 16; k++)
      begin
        rnd = $random(seed);
        weight_mem[p][k] = op_t'(rnd);
        if (T_RELU[row] != 0 && (k % 4) != 3)
          weight_mem[p][k][OP_WIDTH-1] = 1'b1;  // mostly negative weights
      end
    n = T_LEN[row] * T_GROUPS[row];
    for (int v = 0; v < n; v++)
      for (int l = 0; l < NUM_PE; l++)
      begin
        rnd = $random(seed);
        vec_mem[v][l*OP_WIDTH +: OP_WIDTH] = op_t'(rnd);
      end
    for (int p = 0; p < NUM_PU; p++)
      for (int g = 0; g < T_GROUPS[row]; g++)
        exp_mem[p][g] = expected_result(p, g, row);
  endtask

  // ============================================================
  // drivers
  // ============================================================
  task automatic load_weights();
    for (int p = 0; p < NUM_PU; p++)
      for (int k = 0; k < 16; k++)
      begin
        @(posedge clk);
        wb_write <= 1'b1;
        wb_pu    <= 1'(p);
        wb_addr  <= wb_addr_t'(k);
        wb_data  <= weight_mem[p][k];
      end
    @(posedge clk);
    wb_write <= 1'b0;
  endtask

  // pushes at most every other cycle, so a push seen not full is always taken
  task automatic feed_vectors(input int n);
    int   idx;
    logic can_push;
    idx = 0;
    while (idx < n)
    begin
      @(negedge clk);
      // FIFO starts empty, so it cannot be full before DEPTH pushes
      if (stream_full && idx < FIFO_DEPTH)
      begin
        flow_errors++;
        $display("stream_full was high with only %0d vectors pushed", idx);
      end
      can_push = !stream_full && !stream_push;
      @(posedge clk);
      if (can_push)
      begin
        stream_push <= 1'b1;
        stream_data <= vec_mem[idx];
        idx++;
      end
      else
        stream_push <= 1'b0;
    end
    @(posedge clk);
    stream_push <= 1'b0;
  endtask

  task automatic drive_control(input int row);
    repeat (20) @(posedge clk);  // let the FIFO fill first
    start            <= 1'b1;
    cfg_group_len    <= layer_param_t'(T_LEN[row]);
    cfg_num_groups   <= layer_param_t'(T_GROUPS[row]);
    cfg_active_lanes <= LANE_W'(T_LANES[row]);
    cfg_relu         <= (T_RELU[row] != 0);
    outbuf_full      <= NUM_PU'(T_HOLD[row]);
    @(posedge clk);
    start <= 1'b0;
    // write while busy, must not reach the weight buffer
    repeat (3) @(posedge clk);
    wb_write <= 1'b1;
    wb_pu    <= 1'b0;
    wb_addr  <= '0;
    wb_data  <= ~weight_mem[0][0];
    @(posedge clk);
    wb_write <= 1'b0;
    repeat (HOLD_CYCLES) @(posedge clk);
    outbuf_full <= '0;
  endtask

  task automatic wait_done(input int row, input int limit);
    int cycles;
    cycles = 0;
    while (done_cnt == done_base && cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (done_cnt == done_base)
    begin
      run_errors++;
      $display("test %0d: done did not arrive within %0d cycles", row, limit);
    end
  endtask

  task automatic run_test(input int row);
    int n;
    n = T_LEN[row] * T_GROUPS[row];
    $display("test %0d: group_len %0d, groups %0d, lanes %0d, relu %0d, hold %0d",
             row, T_LEN[row], T_GROUPS[row], T_LANES[row], T_RELU[row], T_HOLD[row]);
    prepare_data(row);
    load_weights();
    for (int p = 0; p < NUM_PU; p++)
      base_cnt[p] = got_cnt[p];
    done_base  = done_cnt;
    exp_groups = T_GROUPS[row];
    fork
      feed_vectors(n);
      drive_control(row);
    join
    wait_done(row, 2 * n + 200);
    repeat (4) @(posedge clk);
    if (done_cnt - done_base != 1)
    begin
      run_errors++;
      $display("test %0d: done pulsed %0d times instead of once", row, done_cnt - done_base);
    end
    for (int p = 0; p < NUM_PU; p++)
      if (got_cnt[p] - base_cnt[p] != exp_groups)
      begin
        run_errors++;
        $display("test %0d: PU %0d pushed %0d results, expected %0d",
                 row, p, got_cnt[p] - base_cnt[p], exp_groups);
      end
  endtask

  // ============================================================
  // output monitor, sampled mid-cycle
  // ============================================================
  always @(negedge clk)
  begin
    int idx;
    if (!reset)
    begin
      for (int p = 0; p < NUM_PU; p++)
      begin
        if (out_push[p])
        begin
          if (outbuf_full[p])
          begin
            flow_errors++;
            $display("PU %0d pushed while its output buffer was full", p);
          end
          idx = got_cnt[p] - base_cnt[p];
          if (idx >= exp_groups)
          begin
            flow_errors++;
            $display("PU %0d pushed a result beyond the expected %0d", p, exp_groups);
          end
          else
          begin
            checks++;
            if (out_data[p*VEC_W +: VEC_W] !== exp_mem[p][idx])
            begin
              value_errors++;
              $display("ERROR out_data[%0d] result %0d: expected %h, got %h",
                       p, idx, exp_mem[p][idx], out_data[p*VEC_W +: VEC_W]);
            end
          end
          got_cnt[p]++;
        end
      end
      if (done)
      begin
        done_cnt++;
        if (!push_prev)
        begin
          flow_errors++;
          $display("done did not come one cycle after the last result push");
        end
        for (int p = 0; p < NUM_PU; p++)
          if (got_cnt[p] - base_cnt[p] != exp_groups)
          begin
            flow_errors++;
            $display("done came before PU %0d pushed all its results", p);
          end
      end
      push_prev = |out_push;
    end
  end

  // watchdog sized from the total vector count
  initial
  begin
    longint limit;
    limit = 20;
    for (int r = 0; r < NUM_TESTS; r++)
      limit += 2 * T_LEN[r] * T_GROUPS[r] + HOLD_CYCLES + 500;
    #(limit * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    start            = 1'b0;
    cfg_group_len    = '0;
    cfg_num_groups   = '0;
    cfg_active_lanes = '0;
    cfg_relu         = 1'b0;
    stream_push      = 1'b0;
    stream_data      = '0;
    wb_write         = 1'b0;
    wb_pu            = 1'b0;
    wb_addr          = '0;
    wb_data          = '0;
    outbuf_full      = '0;
    wait (reset === 1'b0);
    @(posedge clk);
    for (int row = 0; row < NUM_TESTS; row++)
      run_test(row);
    $display("checks %0d, value errors %0d, flow errors %0d, run errors %0d",
             checks, value_errors, flow_errors, run_errors);
    if (value_errors + flow_errors + run_errors == 0 && checks > 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- files.f
hdl/dnn_pkg.sv
hdl/stream_fifo.sv
hdl/vectorgen.sv
hdl/pu_controller.sv
hdl/processing_unit.sv
hdl/dnn_accelerator.sv
verif/clock_gen.sv
verif/tb_dnn_accelerator.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the DNN accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_dnn_accelerator
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" \
  -f files.f --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  echo "run passed"
  exit 0
fi
echo "run failed"
exit 1
